// File: src/pipe_macros.svh
/*
 * Sizing constants for the execution pipeline.
 * Included by the package, the RTL and the testbench.
 */
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

`define WORD_BITS     32
`define REG_COUNT     32
`define BYPASS_DEPTH  3
`define READ_PORTS    2
`define DMEM_WORDS    16

// Data table entry i holds i * DMEM_SEED + i
`define DMEM_SEED     32'h9E37_79B1

`endif

// File: src/PipeTypes.sv
/*
 * Shared types for the execution pipeline.
 * Opcodes and the structs passed between the stages, the bypass
 * network and the register file.
 */
`include "pipe_macros.svh"

package PipeTypes;

    typedef logic [`WORD_BITS-1:0] Word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] RegAddr_t;

    typedef enum logic [2:0] {
        OpAdd,
        OpSub,
        OpAnd,
        OpOr,
        OpXor,
        OpSll,
        OpAddi,
        OpLoad
    } Opcode_t;

    // Decoded op as presented by the issuer
    typedef struct packed {
        logic     valid;
        Opcode_t  op;
        RegAddr_t rd;
        RegAddr_t rs1;
        RegAddr_t rs2;
        Word_t    imm;
    } IssueOp_t;

    // Op with operands resolved, held in Execute
    typedef struct packed {
        logic     valid;
        Opcode_t  op;
        RegAddr_t rd;
        Word_t    operand1;
        Word_t    operand2;
        Word_t    imm;
    } ExecOp_t;

    // Op held in Memory; value is the load address for loads
    typedef struct packed {
        logic     valid;
        logic     isLoad;
        RegAddr_t rd;
        Word_t    value;
    } MemOp_t;

    typedef struct packed {
        logic     enable;
        RegAddr_t addr;
        Word_t    value;
    } RegWrite_t;

    typedef struct packed {
        logic  hit;
        Word_t value;
    } RegRead_t;

endpackage

// File: src/RegisterFile.sv
/*
 * Integer register file with two combinational read ports and one
 * synchronous write port. Register zero always reads as zero.
 */
`timescale 1ns/1ns
`include "pipe_macros.svh"

module RegisterFile (
    input  logic                                     clk,
    input  logic                                     rstN,
    input  PipeTypes::RegAddr_t [`READ_PORTS-1:0]    readAddr,
    output PipeTypes::Word_t    [`READ_PORTS-1:0]    readValue,
    input  PipeTypes::RegWrite_t                     write,
    input  logic                                     stall
);

    PipeTypes::Word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write.enable && write.addr != '0) begin
            regs[write.addr] <= write.value;
        end
    end

    always_comb begin
        for (int i = 0; i < `READ_PORTS; i++) begin
            if (readAddr[i] == '0) begin
                readValue[i] = '0;
            end else begin
                readValue[i] = regs[readAddr[i]];
            end
        end
    end

    // Top level must hold the register file frozen during a stall
    noWriteWhileStall: assert property (
        @(posedge clk) disable iff (!rstN) !(write.enable && stall)
    );

endmodule

// File: src/BypassNetwork.sv
/*
 * Forwarding network for results not yet in the register file.
 * A short shift pipeline of pending writes is searched by each read
 * port; the load write of the current cycle takes priority.
 */
`timescale 1ns/1ns
`include "pipe_macros.svh"

module BypassNetwork (
    input  logic                                     clk,
    input  logic                                     rstN,
    input  logic                                     stall,
    input  logic                                     flush,
    input  PipeTypes::RegAddr_t  [`READ_PORTS-1:0]   readAddr,
    output PipeTypes::RegRead_t  [`READ_PORTS-1:0]   readResult,
    input  PipeTypes::RegWrite_t                     aluWrite,
    input  PipeTypes::RegWrite_t                     loadWrite
);

    localparam int IndexBits = $clog2(`BYPASS_DEPTH);

    typedef logic [IndexBits-1:0] SlotIndex_t;

    // Lowest set bit wins, so the youngest entry is forwarded
    function automatic SlotIndex_t lowestIndex(logic [`BYPASS_DEPTH-1:0] hits);
        for (int i = 0; i < `BYPASS_DEPTH; i++) begin
            if (hits[i]) begin
                return SlotIndex_t'(i);
            end
        end
        return '0;
    endfunction

    PipeTypes::RegWrite_t slots [`BYPASS_DEPTH];

    logic [`READ_PORTS-1:0]   loadHit;
    logic [`BYPASS_DEPTH-1:0] camHits [`READ_PORTS];
    SlotIndex_t               camIndex [`READ_PORTS];

    always_comb begin
        for (int i = 0; i < `READ_PORTS; i++) begin
            loadHit[i] = loadWrite.enable && (loadWrite.addr == readAddr[i]);
            for (int j = 0; j < `BYPASS_DEPTH; j++) begin
                camHits[i][j] = slots[j].enable && (slots[j].addr == readAddr[i]);
            end
            camIndex[i] = lowestIndex(camHits[i]);

            if (readAddr[i] == '0) begin
                // x0 never forwards
                readResult[i].hit   = 1'b0;
                readResult[i].value = '0;
            end else if (loadHit[i]) begin
                readResult[i].hit   = 1'b1;
                readResult[i].value = loadWrite.value;
            end else if (|camHits[i]) begin
                readResult[i].hit   = 1'b1;
                readResult[i].value = slots[camIndex[i]].value;
            end else begin
                // Miss, register file supplies the value
                readResult[i].hit   = 1'b0;
                readResult[i].value = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            for (int i = 0; i < `BYPASS_DEPTH; i++) begin
                slots[i] <= '0;
            end
        end else if (!stall) begin
            slots[0] <= aluWrite;
            // Load data lands one slot deep, beside its own empty ALU slot
            slots[1] <= loadWrite.enable ? loadWrite : slots[0];
            for (int i = 2; i < `BYPASS_DEPTH; i++) begin
                slots[i] <= slots[i-1];
            end
        end
    end

    // A live ALU entry in slot 0 would be lost when a load takes slot 1
    loadSlotFree: assert property (
        @(posedge clk) disable iff (!rstN)
        loadWrite.enable |-> (!slots[0].enable || slots[0].addr == loadWrite.addr)
    );

endmodule

// File: src/OperandFetch.sv
/*
 * Operand read stage. Takes the decoded op from the issuer, resolves
 * both source operands from the bypass or the register file, and
 * registers the op toward Execute.
 */
`timescale 1ns/1ns
`include "pipe_macros.svh"

module OperandFetch (
    input  logic                                     clk,
    input  logic                                     rstN,
    input  logic                                     stall,
    input  logic                                     flush,
    input  PipeTypes::IssueOp_t                      issue,
    output PipeTypes::RegAddr_t  [`READ_PORTS-1:0]   readAddr,
    input  PipeTypes::RegRead_t  [`READ_PORTS-1:0]   bypassResult,
    input  PipeTypes::Word_t     [`READ_PORTS-1:0]   regValue,
    output PipeTypes::ExecOp_t                       execOp
);

    PipeTypes::Word_t operand [`READ_PORTS];
    PipeTypes::Word_t secondOperand;
    logic             useImm;

    assign readAddr[0] = issue.rs1;
    assign readAddr[1] = issue.rs2;

    always_comb begin
        for (int i = 0; i < `READ_PORTS; i++) begin
            operand[i] = bypassResult[i].hit ? bypassResult[i].value : regValue[i];
        end
    end

    // Immediate forms ignore rs2
    assign useImm = (issue.op == PipeTypes::OpAddi) || (issue.op == PipeTypes::OpLoad);
    assign secondOperand = useImm ? issue.imm : operand[1];

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            execOp.valid <= 1'b0;
        end else if (!stall) begin
            execOp.valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            execOp.op       <= issue.op;
            execOp.rd       <= issue.rd;
            execOp.operand1 <= operand[0];
            execOp.operand2 <= secondOperand;
            execOp.imm      <= issue.imm;
        end
    end

endmodule

// File: src/AluStage.sv
/*
 * Execute stage. Computes the ALU result, or the address for a load,
 * posts ALU results to the bypass in the same cycle, and registers
 * the op toward Memory.
 */
`timescale 1ns/1ns

module AluStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  stall,
    input  logic                  flush,
    input  PipeTypes::ExecOp_t    execOp,
    output PipeTypes::RegWrite_t  aluWrite,
    output PipeTypes::MemOp_t     memOp
);

    PipeTypes::Word_t aluResult;
    logic             isLoad;

    assign isLoad = (execOp.op == PipeTypes::OpLoad);

    always_comb begin
        case (execOp.op)
            PipeTypes::OpAdd:  aluResult = execOp.operand1 + execOp.operand2;
            PipeTypes::OpSub:  aluResult = execOp.operand1 - execOp.operand2;
            PipeTypes::OpAnd:  aluResult = execOp.operand1 & execOp.operand2;
            PipeTypes::OpOr:   aluResult = execOp.operand1 | execOp.operand2;
            PipeTypes::OpXor:  aluResult = execOp.operand1 ^ execOp.operand2;
            // Shift amount from the low five bits only
            PipeTypes::OpSll:  aluResult = execOp.operand1 << execOp.operand2[4:0];
            PipeTypes::OpAddi: aluResult = execOp.operand1 + execOp.operand2;
            PipeTypes::OpLoad: aluResult = execOp.operand1 + execOp.imm;
            default:           aluResult = '0;
        endcase
    end

    // Loads forward later, from Memory
    assign aluWrite.enable = execOp.valid && !isLoad && (execOp.rd != '0);
    assign aluWrite.addr   = execOp.rd;
    assign aluWrite.value  = aluResult;

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            memOp.valid <= 1'b0;
        end else if (!stall) begin
            memOp.valid <= execOp.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            memOp.isLoad <= isLoad;
            memOp.rd     <= execOp.rd;
            memOp.value  <= aluResult;
        end
    end

endmodule

// File: src/LoadStage.sv
/*
 * Memory stage. Reads load data from a fixed read-only table, posts
 * it to the bypass in the same cycle, and registers the Writeback
 * write for every op.
 */
`timescale 1ns/1ns
`include "pipe_macros.svh"

module LoadStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  stall,
    input  logic                  flush,
    input  PipeTypes::MemOp_t     memOp,
    output PipeTypes::RegWrite_t  loadWrite,
    output PipeTypes::RegWrite_t  wbWrite
);

    localparam int IndexBits = $clog2(`DMEM_WORDS);

    PipeTypes::Word_t       dataTable [`DMEM_WORDS];
    logic [IndexBits-1:0]   tableIndex;
    PipeTypes::Word_t       stageValue;

    // Fixed contents, entry i is i * seed + i
    always_comb begin
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            dataTable[i] = PipeTypes::Word_t'(i * `DMEM_SEED + i);
        end
    end

    // Word addressed, wraps over the table
    assign tableIndex = memOp.value[2 +: IndexBits];

    assign loadWrite.enable = memOp.valid && memOp.isLoad;
    assign loadWrite.addr   = memOp.rd;
    assign loadWrite.value  = dataTable[tableIndex];

    assign stageValue = memOp.isLoad ? dataTable[tableIndex] : memOp.value;

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            wbWrite.enable <= 1'b0;
        end else if (!stall) begin
            wbWrite.enable <= memOp.valid && (memOp.rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wbWrite.addr  <= memOp.rd;
            wbWrite.value <= stageValue;
        end
    end

    // Issuer and Execute together must produce word-aligned addresses
    alignedLoad: assert property (
        @(posedge clk) disable iff (!rstN)
        (memOp.valid && memOp.isLoad) |-> (memOp.value[1:0] == 2'b00)
    );

endmodule

// File: src/ExecPipeTop.sv
/*
 * Top of the four-stage execution pipeline. Connects operand fetch,
 * execute, memory and the register file around the bypass network.
 * The issuer presents decoded ops and drives stall and flush levels.
 */
`timescale 1ns/1ns
`include "pipe_macros.svh"

module ExecPipeTop (
    input  logic                  clk,
    input  logic                  rstN,
    input  PipeTypes::IssueOp_t   issue,
    input  logic                  stall,
    input  logic                  flush,
    output PipeTypes::RegWrite_t  retire
);

    PipeTypes::RegAddr_t  [`READ_PORTS-1:0] readAddr;
    PipeTypes::RegRead_t  [`READ_PORTS-1:0] bypassResult;
    PipeTypes::Word_t     [`READ_PORTS-1:0] regValue;
    PipeTypes::ExecOp_t                     execOp;
    PipeTypes::MemOp_t                      memOp;
    PipeTypes::RegWrite_t                   aluWrite;
    PipeTypes::RegWrite_t                   loadWrite;
    PipeTypes::RegWrite_t                   wbWrite;

    // Writeback is dropped on a flush and held back on a stall
    assign retire = '{
        enable: wbWrite.enable && !stall && !flush,
        addr:   wbWrite.addr,
        value:  wbWrite.value
    };

    OperandFetch fetchStage (
        .clk(clk), .rstN(rstN), .stall(stall), .flush(flush),
        .issue(issue), .readAddr(readAddr), .bypassResult(bypassResult),
        .regValue(regValue), .execOp(execOp)
    );

    BypassNetwork bypass (
        .clk(clk), .rstN(rstN), .stall(stall), .flush(flush),
        .readAddr(readAddr), .readResult(bypassResult),
        .aluWrite(aluWrite), .loadWrite(loadWrite)
    );

    RegisterFile regFile (
        .clk(clk), .rstN(rstN), .readAddr(readAddr), .readValue(regValue),
        .write(retire), .stall(stall)
    );

    AluStage aluStage (
        .clk(clk), .rstN(rstN), .stall(stall), .flush(flush),
        .execOp(execOp), .aluWrite(aluWrite), .memOp(memOp)
    );

    LoadStage loadStage (
        .clk(clk), .rstN(rstN), .stall(stall), .flush(flush),
        .memOp(memOp), .loadWrite(loadWrite), .wbWrite(wbWrite)
    );

endmodule

// File: dv/ExecPipeTb.sv
/*
 * Testbench for the execution pipeline. Issues directed and LCG ops,
 * predicts every retire from a model register file and the data table
 * formula, and checks retire order, timing and values.
 */
`timescale 1ns/1ns
`include "pipe_macros.svh"

module ExecPipeTb;

    localparam int ClockPeriod = 4;
    localparam int RandomOps   = 200;
    // Random ops with stalls plus the directed tests and drains
    localparam int WatchCycles = RandomOps * 3 + 400;

    typedef struct {
        PipeTypes::RegAddr_t addr;
        PipeTypes::Word_t    value;
        int                  tag;
    } Expect_t;

    logic                 clk;
    logic                 rstN;
    logic                 stall;
    logic                 flush;
    PipeTypes::IssueOp_t  issue;
    PipeTypes::RegWrite_t retire;

    Expect_t             expQ[$];
    PipeTypes::Word_t    modelRegs [`REG_COUNT];
    PipeTypes::RegAddr_t lastRd;
    int                  activeCount;
    int                  checkCount;
    int                  errorCount;
    int                  testCount;
    int                  startErrors;
    string               testName;
    logic [31:0]         lcgState = 32'd15834;

    ExecPipeTop dut_i (
        .clk(clk), .rstN(rstN), .issue(issue), .stall(stall), .flush(flush),
        .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #(ClockPeriod / 2) clk = ~clk;
    end

    initial begin
        #(WatchCycles * ClockPeriod);
        $display("Timeout: the run did not finish within %0d cycles", WatchCycles);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 4;
    endfunction

    function automatic PipeTypes::Word_t tableWord(PipeTypes::Word_t addr);
        int unsigned idx;
        idx = (addr >> 2) % `DMEM_WORDS;
        return PipeTypes::Word_t'(idx * `DMEM_SEED + idx);
    endfunction

    function automatic PipeTypes::Word_t refResult(PipeTypes::Opcode_t op,
            PipeTypes::Word_t a, PipeTypes::Word_t b, PipeTypes::Word_t imm);
        case (op)
            PipeTypes::OpAdd:  return a + b;
            PipeTypes::OpSub:  return a - b;
            PipeTypes::OpAnd:  return a & b;
            PipeTypes::OpOr:   return a | b;
            PipeTypes::OpXor:  return a ^ b;
            PipeTypes::OpSll:  return a << b[4:0];
            PipeTypes::OpAddi: return a + imm;
            default:           return tableWord(a + imm);
        endcase
    endfunction

    // Youngest pending write wins over the committed model
    function automatic PipeTypes::Word_t sourceValue(PipeTypes::RegAddr_t r);
        if (r == '0) begin
            return '0;
        end
        for (int i = expQ.size() - 1; i >= 0; i--) begin
            if (expQ[i].addr == r) begin
                return expQ[i].value;
            end
        end
        return modelRegs[r];
    endfunction

    function automatic PipeTypes::IssueOp_t makeOp(PipeTypes::Opcode_t op, int rd, int rs1,
            int rs2, int imm);
        PipeTypes::IssueOp_t o;
        o.valid = 1'b1;
        o.op    = op;
        o.rd    = PipeTypes::RegAddr_t'(rd);
        o.rs1   = PipeTypes::RegAddr_t'(rs1);
        o.rs2   = PipeTypes::RegAddr_t'(rs2);
        o.imm   = PipeTypes::Word_t'(imm);
        return o;
    endfunction

    // Drives one cycle of stimulus and predicts the retire of an accepted op
    task automatic driveCycle(PipeTypes::IssueOp_t op, logic st, logic fl);
        Expect_t e;
        @(negedge clk);
        issue = op;
        stall = st;
        flush = fl;
        if (op.valid && !st && !fl) begin
            if (op.rd != '0) begin
                e.addr  = op.rd;
                e.value = refResult(op.op, sourceValue(op.rs1), sourceValue(op.rs2), op.imm);
                e.tag   = activeCount;
                expQ.push_back(e);
            end
            lastRd = op.rd;
        end else if (!st) begin
            lastRd = '0;
        end
    endtask

    task automatic drain();
        while (expQ.size() > 0) begin
            driveCycle('0, 1'b0, 1'b0);
        end
        driveCycle('0, 1'b0, 1'b0);
    endtask

    task automatic beginTest(string name);
        testName    = name;
        startErrors = errorCount;
    endtask

    task automatic endTest();
        drain();
        testCount++;
        if (errorCount == startErrors) begin
            $display("test %s: ok", testName);
        end else begin
            $display("test %s: %0d errors", testName, errorCount - startErrors);
        end
    endtask

    // Retire must match the queue head exactly 3 active cycles after issue
    always @(posedge clk) begin
        Expect_t head;
        if (rstN) begin
            // A flush drops everything in flight, the op in Writeback included
            if (flush) begin
                expQ.delete();
            end
            assert (!(stall && retire.enable)) else begin
                errorCount++;
                $display("Retire appeared while stall was high in %s", testName);
            end
            if (retire.enable) begin
                assert (expQ.size() > 0) else begin
                    errorCount++;
                    $display("Retire to x%0d appeared when none was expected in %s",
                             retire.addr, testName);
                end
                if (expQ.size() > 0) begin
                    head = expQ.pop_front();
                    checkCount++;
                    assert (retire.addr == head.addr && retire.value == head.value &&
                            activeCount == head.tag + 3) else begin
                        errorCount++;
                        $display("CHECK FAILED %s: expected x%0d=%h at %0d, actual x%0d=%h at %0d",
                                 testName, head.addr, head.value, head.tag + 3,
                                 retire.addr, retire.value, activeCount);
                    end
                    modelRegs[head.addr] = head.value;
                end
            end else if (!stall && expQ.size() > 0) begin
                assert (expQ[0].tag + 3 != activeCount) else begin
                    errorCount++;
                    $display("Expected retire to x%0d did not appear in %s",
                             expQ[0].addr, testName);
                    head = expQ.pop_front();
                    modelRegs[head.addr] = head.value;
                end
            end
            if (!stall) begin
                activeCount++;
            end
        end
    end

    initial begin
        PipeTypes::IssueOp_t op;
        logic [31:0]         r;
        rstN = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        issue = '0;
        lastRd = '0;
        activeCount = 0;
        checkCount = 0;
        errorCount = 0;
        testCount = 0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        beginTest("alu_ops");
        for (int i = 1; i <= 8; i++) begin
            driveCycle(makeOp(PipeTypes::OpAddi, i, 0, 0, i * 32'h1357_9BDF), 1'b0, 1'b0);
        end
        driveCycle(makeOp(PipeTypes::OpAdd, 10, 1, 2, 0), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpSub, 11, 3, 4, 0), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpAnd, 12, 5, 6, 0), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpOr, 13, 7, 8, 0), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpXor, 14, 1, 3, 0), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpSll, 15, 2, 4, 0), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpAddi, 16, 5, 0, -7), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpLoad, 17, 0, 0, 32'h24), 1'b0, 1'b0);
        endTest();

        beginTest("forwarding");
        driveCycle(makeOp(PipeTypes::OpAddi, 20, 1, 0, 5), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpXor, 21, 2, 3, 0), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpAdd, 22, 20, 1, 0), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpSub, 23, 21, 20, 0), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpLoad, 24, 0, 0, 32'h18), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpOr, 25, 22, 23, 0), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpAdd, 26, 24, 24, 0), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpXor, 27, 24, 25, 0), 1'b0, 1'b0);
        endTest();

        beginTest("register_zero");
        // The load to x0 is still pending in the bypass while x0 is read
        driveCycle(makeOp(PipeTypes::OpLoad, 0, 0, 0, 32'h1c), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpAddi, 0, 1, 0, 99), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpAdd, 28, 0, 1, 0), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpOr, 29, 0, 0, 0), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpAdd, 0, 2, 3, 0), 1'b0, 1'b0);
        endTest();

        beginTest("stall");
        for (int i = 0; i < 8; i++) begin
            op = makeOp(PipeTypes::OpAddi, 10 + i, (i >= 2) ? 8 + i : 1, 0, i * 3 + 1);
            repeat (nextRandom() % 3) driveCycle(op, 1'b1, 1'b0);
            driveCycle(op, 1'b0, 1'b0);
        end
        endTest();

        beginTest("flush");
        driveCycle(makeOp(PipeTypes::OpAddi, 10, 0, 0, 32'h111), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpAddi, 11, 0, 0, 32'h222), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpLoad, 12, 0, 0, 8), 1'b0, 1'b0);
        driveCycle('0, 1'b0, 1'b1);
        driveCycle(makeOp(PipeTypes::OpAdd, 13, 10, 11, 0), 1'b0, 1'b0);
        driveCycle(makeOp(PipeTypes::OpOr, 14, 12, 0, 0), 1'b0, 1'b0);
        endTest();

        beginTest("random");
        for (int n = 0; n < RandomOps; n++) begin
            r  = nextRandom();
            op = makeOp(PipeTypes::Opcode_t'(r % 8), (r >> 3) % 32, (r >> 8) % 32,
                        (r >> 13) % 32, 0);
            op.imm = {{20{r[27]}}, r[27:16]};
            if (op.op == PipeTypes::OpLoad) begin
                op.rs1 = '0;
                op.imm = {25'b0, r[20:16], 2'b00};
            end
            // Keep clear of the op issued one cycle earlier
            if (lastRd != '0 && op.rs1 == lastRd) begin
                op.rs1 = op.rs1 ^ 5'd1;
            end
            if (lastRd != '0 && op.rs2 == lastRd) begin
                op.rs2 = op.rs2 ^ 5'd1;
            end
            if (nextRandom() % 8 == 0) begin
                repeat (1 + nextRandom() % 2) driveCycle(op, 1'b1, 1'b0);
            end
            driveCycle(op, 1'b0, 1'b0);
        end
        endTest();

        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+src
src/PipeTypes.sv
src/RegisterFile.sv
src/BypassNetwork.sv
src/OperandFetch.sv
src/AluStage.sv
src/LoadStage.sv
src/ExecPipeTop.sv
dv/ExecPipeTb.sv

// File: run.sh
#!/bin/sh
# Build and run the execution pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module ExecPipeTb -f project.f -o simExecPipe > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/simExecPipe > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
